/* verilog/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// First fetch address after reset
`define CPU_RESET_PC 16'h0200

// Opcode that stops the core
`define CPU_OP_BRK 8'h00

// High address byte for all zero-page accesses
`define CPU_ZP_PAGE 8'h00

`endif

/* verilog/cpu_pkg.sv */
package cpu_pkg;

    // Opcode byte
    // --------------------
    typedef struct packed {
        logic [2:0] grp_op;
        logic [2:0] mode_bits;
        logic [1:0] group;
    } opcode_fields_t;

    // Same byte, seen raw or split into aaa/bbb/cc
    typedef union packed {
        logic [7:0]     raw;
        opcode_fields_t fields;
    } opcode_u;

    // Decode enums
    // --------------------
    typedef enum logic [2:0] {IMP, IMM, ZP, ZPX, ABS, ABX, ABY} addr_mode_e;

    // Order follows the aaa field
    typedef enum logic [2:0] {ORA, AND, EOR, ADC, STA, LDA, CMP, SBC} alu_op_e;

    typedef enum logic [1:0] {NONE, A, X, Y} reg_sel_e;

    typedef enum logic [1:0] {KEEP, CLC, SEC} flag_op_e;

    // Records
    // --------------------
    // Only N, V, Z and C of P are kept
    typedef struct packed {
        logic n;
        logic v;
        logic z;
        logic c;
    } flags_t;

    typedef struct packed {
        addr_mode_e mode;
        alu_op_e    alu_op;
        reg_sel_e   dest;
        logic       index_y;
        logic       is_store;
        flag_op_e   flag_op;
        logic       halt;
    } decode_t;

    typedef struct packed {
        logic [15:0] address;
        logic [7:0]  wdata;
        logic        wreq;
    } bus_req_t;

    // Per-cycle strobes from the sequencer
    typedef struct packed {
        logic pc_inc;
        logic load_lo;
        logic load_hi;
        logic use_operand;
        logic exec;
        logic fetch;
    } seq_ctl_t;

endpackage

/* verilog/cpu_decoder.sv */
`include "cpu_macros.svh"

module cpu_decoder (
    input  cpu_pkg::opcode_u opcode,
    output cpu_pkg::decode_t dec
);

    logic supported;

    always_comb begin
        // Anything unknown runs as a one-byte no-operation
        dec.mode     = cpu_pkg::IMP;
        dec.alu_op   = cpu_pkg::STA;
        dec.dest     = cpu_pkg::NONE;
        dec.index_y  = 1'b0;
        dec.is_store = 1'b0;
        dec.flag_op  = cpu_pkg::KEEP;
        dec.halt     = 1'b0;
        supported    = 1'b1;

        if (opcode.fields.group == 2'b01) begin
            // Group one, aaa_bbb_01
            case (opcode.fields.mode_bits)
                3'b010:  dec.mode = cpu_pkg::IMM;
                3'b001:  dec.mode = cpu_pkg::ZP;
                3'b101:  dec.mode = cpu_pkg::ZPX;
                3'b011:  dec.mode = cpu_pkg::ABS;
                3'b111:  dec.mode = cpu_pkg::ABX;
                3'b110: begin
                    dec.mode    = cpu_pkg::ABY;
                    dec.index_y = 1'b1;
                end
                // Indirect modes are not implemented
                default: supported = 1'b0;
            endcase

            dec.alu_op = cpu_pkg::alu_op_e'(opcode.fields.grp_op);

            // STA immediate has no meaning
            if (dec.alu_op == cpu_pkg::STA && dec.mode == cpu_pkg::IMM) begin
                supported = 1'b0;
            end

            if (supported) begin
                dec.is_store = (dec.alu_op == cpu_pkg::STA);
                if (dec.alu_op != cpu_pkg::STA && dec.alu_op != cpu_pkg::CMP) begin
                    dec.dest = cpu_pkg::A;
                end
            end else begin
                dec.mode    = cpu_pkg::IMP;
                dec.alu_op  = cpu_pkg::STA;
                dec.index_y = 1'b0;
            end
        end else begin
            case (opcode.raw)
                8'hA2: begin
                    dec.mode = cpu_pkg::IMM;
                    dec.dest = cpu_pkg::X;
                end
                8'hA0: begin
                    dec.mode = cpu_pkg::IMM;
                    dec.dest = cpu_pkg::Y;
                end
                8'h18:       dec.flag_op = cpu_pkg::CLC;
                8'h38:       dec.flag_op = cpu_pkg::SEC;
                `CPU_OP_BRK: dec.halt    = 1'b1;
                default:     dec.halt    = 1'b0;
            endcase
        end
    end

endmodule

/* verilog/cpu_sequencer.sv */
module cpu_sequencer (
    input  logic              cpu_clock,
    input  logic              rst_n,
    input  logic [7:0]        i_data,
    output cpu_pkg::seq_ctl_t ctl,
    output cpu_pkg::decode_t  cur,
    output logic              halt
);

    typedef enum logic [2:0] {FETCH, OPER_LO, OPER_HI, EXEC, HALTED} state_e;

    state_e            state;
    state_e            state_next;
    cpu_pkg::opcode_u  op_word;
    cpu_pkg::decode_t  dec;
    logic              is_abs;

    // Opcode is only meaningful in the fetch cycle
    assign op_word.raw = i_data;

    cpu_decoder decoder_i (
        .opcode (op_word),
        .dec    (dec)
    );

    assign is_abs = (cur.mode == cpu_pkg::ABS) ||
                    (cur.mode == cpu_pkg::ABX) ||
                    (cur.mode == cpu_pkg::ABY);

    // Next state
    // --------------------
    always_comb begin
        state_next = state;
        case (state)
            FETCH: begin
                if (dec.halt) begin
                    state_next = HALTED;
                end else if (dec.mode == cpu_pkg::IMP || dec.mode == cpu_pkg::IMM) begin
                    state_next = EXEC;
                end else begin
                    state_next = OPER_LO;
                end
            end
            OPER_LO: state_next = is_abs ? OPER_HI : EXEC;
            OPER_HI: state_next = EXEC;
            EXEC:    state_next = FETCH;
            HALTED:  state_next = HALTED;
            default: state_next = FETCH;
        endcase
    end

    // Strobes for this cycle
    // --------------------
    always_comb begin
        ctl = '0;
        case (state)
            FETCH: begin
                ctl.fetch  = 1'b1;
                ctl.pc_inc = 1'b1;
            end
            OPER_LO: begin
                ctl.load_lo = 1'b1;
                ctl.pc_inc  = 1'b1;
            end
            OPER_HI: begin
                ctl.load_hi = 1'b1;
                ctl.pc_inc  = 1'b1;
            end
            EXEC: begin
                ctl.exec = 1'b1;
                // Immediate operand sits at the PC
                ctl.pc_inc = (cur.mode == cpu_pkg::IMM);
                ctl.use_operand = (cur.mode != cpu_pkg::IMP) &&
                                  (cur.mode != cpu_pkg::IMM);
            end
            default: ctl = '0;
        endcase
    end

    always_ff @(posedge cpu_clock) begin
        if (!rst_n) begin
            state <= FETCH;
            cur   <= '0;
        end else begin
            state <= state_next;
            if (ctl.fetch) begin
                cur <= dec;
            end
        end
    end

    assign halt = (state == HALTED);

endmodule

/* verilog/cpu_addr_gen.sv */
`include "cpu_macros.svh"

module cpu_addr_gen (
    input  logic                cpu_clock,
    input  logic                rst_n,
    input  cpu_pkg::seq_ctl_t   ctl,
    input  cpu_pkg::addr_mode_e mode,
    input  logic                index_y,
    input  logic [7:0]          x,
    input  logic [7:0]          y,
    input  logic [7:0]          i_data,
    output logic [15:0]         address
);

    logic [15:0] pc;
    logic [7:0]  oper_lo;
    logic [7:0]  oper_hi;
    logic [7:0]  index;
    logic [7:0]  zp_index;
    logic [15:0] eff_addr;

    always_ff @(posedge cpu_clock) begin
        if (!rst_n) begin
            pc <= `CPU_RESET_PC;
        end else if (ctl.pc_inc) begin
            pc <= pc + 16'd1;
        end
    end

    // Operand bytes
    always_ff @(posedge cpu_clock) begin
        if (ctl.load_lo) begin
            oper_lo <= i_data;
        end
        if (ctl.load_hi) begin
            oper_hi <= i_data;
        end
    end

    // Effective address
    // --------------------
    assign index    = index_y ? y : x;
    // Wraps inside page zero
    assign zp_index = oper_lo + x;

    always_comb begin
        case (mode)
            cpu_pkg::ZP:  eff_addr = {`CPU_ZP_PAGE, oper_lo};
            cpu_pkg::ZPX: eff_addr = {`CPU_ZP_PAGE, zp_index};
            cpu_pkg::ABX,
            cpu_pkg::ABY: eff_addr = {oper_hi, oper_lo} + {8'h00, index};
            default:      eff_addr = {oper_hi, oper_lo};
        endcase
    end

    assign address = ctl.use_operand ? eff_addr : pc;

endmodule

/* verilog/cpu_alu.sv */
module cpu_alu (
    input  cpu_pkg::alu_op_e op,
    input  logic [7:0]       a,
    input  logic [7:0]       operand,
    input  cpu_pkg::flags_t  flags_in,
    output logic [7:0]       result,
    output cpu_pkg::flags_t  flags_out
);

    logic [8:0] sum;
    logic [8:0] diff;
    logic [8:0] cmp;

    // Subtraction as A + ~M + C, carry set means no borrow
    assign sum  = {1'b0, a} + {1'b0, operand} + {8'h00, flags_in.c};
    assign diff = {1'b0, a} + {1'b0, ~operand} + {8'h00, flags_in.c};
    assign cmp  = {1'b0, a} + {1'b0, ~operand} + 9'd1;

    always_comb begin
        result    = a;
        flags_out = flags_in;

        case (op)
            cpu_pkg::ORA: result = a | operand;
            cpu_pkg::AND: result = a & operand;
            cpu_pkg::EOR: result = a ^ operand;
            cpu_pkg::ADC: begin
                result      = sum[7:0];
                flags_out.v = ~(a[7] ^ operand[7]) & (a[7] ^ sum[7]);
                flags_out.c = sum[8];
            end
            cpu_pkg::SBC: begin
                result      = diff[7:0];
                flags_out.v = (a[7] ^ operand[7]) & (a[7] ^ diff[7]);
                flags_out.c = diff[8];
            end
            cpu_pkg::LDA: result = operand;
            // A stays put, only flags come from the difference
            cpu_pkg::CMP: result = a;
            default:      result = a;
        endcase

        // N and Z follow the result, CMP takes them from A - M
        case (op)
            cpu_pkg::STA: begin
                flags_out.n = flags_in.n;
                flags_out.z = flags_in.z;
            end
            cpu_pkg::CMP: begin
                flags_out.n = cmp[7];
                flags_out.z = (cmp[7:0] == 8'h00);
                flags_out.c = cmp[8];
            end
            default: begin
                flags_out.n = result[7];
                flags_out.z = (result == 8'h00);
            end
        endcase
    end

endmodule

/* verilog/cpu_regfile.sv */
module cpu_regfile (
    input  logic             cpu_clock,
    input  logic             rst_n,
    input  logic             exec,
    input  cpu_pkg::decode_t cur,
    input  logic [7:0]       result,
    input  cpu_pkg::flags_t  flags_new,
    input  logic [7:0]       i_data,
    output logic [7:0]       a,
    output logic [7:0]       x,
    output logic [7:0]       y,
    output cpu_pkg::flags_t  flags
);

    cpu_pkg::flags_t flags_wb;

    // Flags after this instruction
    always_comb begin
        flags_wb = flags_new;
        if (cur.dest == cpu_pkg::X || cur.dest == cpu_pkg::Y) begin
            // Index loads bypass the ALU
            flags_wb   = flags;
            flags_wb.n = i_data[7];
            flags_wb.z = (i_data == 8'h00);
        end
        case (cur.flag_op)
            cpu_pkg::CLC: flags_wb.c = 1'b0;
            cpu_pkg::SEC: flags_wb.c = 1'b1;
            default:      flags_wb.c = flags_wb.c;
        endcase
    end

    always_ff @(posedge cpu_clock) begin
        if (!rst_n) begin
            a     <= 8'h00;
            x     <= 8'h00;
            y     <= 8'h00;
            flags <= '0;
        end else if (exec) begin
            case (cur.dest)
                cpu_pkg::A: a <= result;
                cpu_pkg::X: x <= i_data;
                cpu_pkg::Y: y <= i_data;
                default:    a <= a;
            endcase
            flags <= flags_wb;
        end
    end

endmodule

/* verilog/cpu.sv */
module cpu (
    input  logic              cpu_clock,
    input  logic              rst_n,
    input  logic [7:0]        i_data,
    output cpu_pkg::bus_req_t bus,
    output logic              halt
);

    cpu_pkg::seq_ctl_t ctl;
    cpu_pkg::decode_t  cur;
    cpu_pkg::flags_t   flags;
    cpu_pkg::flags_t   flags_new;
    logic [15:0]       address;
    logic [7:0]        a;
    logic [7:0]        x;
    logic [7:0]        y;
    logic [7:0]        result;

    // Control
    // --------------------
    cpu_sequencer sequencer_i (
        .cpu_clock (cpu_clock),
        .rst_n     (rst_n),
        .i_data    (i_data),
        .ctl       (ctl),
        .cur       (cur),
        .halt      (halt)
    );

    // Datapath
    // --------------------
    cpu_addr_gen addr_gen_i (
        .cpu_clock (cpu_clock),
        .rst_n     (rst_n),
        .ctl       (ctl),
        .mode      (cur.mode),
        .index_y   (cur.index_y),
        .x         (x),
        .y         (y),
        .i_data    (i_data),
        .address   (address)
    );

    cpu_alu alu_i (
        .op        (cur.alu_op),
        .a         (a),
        .operand   (i_data),
        .flags_in  (flags),
        .result    (result),
        .flags_out (flags_new)
    );

    cpu_regfile regfile_i (
        .cpu_clock (cpu_clock),
        .rst_n     (rst_n),
        .exec      (ctl.exec),
        .cur       (cur),
        .result    (result),
        .flags_new (flags_new),
        .i_data    (i_data),
        .a         (a),
        .x         (x),
        .y         (y),
        .flags     (flags)
    );

    // Store writes A in its last cycle
    assign bus.address = address;
    assign bus.wdata   = a;
    assign bus.wreq    = ctl.exec & cur.is_store;

endmodule

/* testbench/cpu_tb_clock.sv */
module cpu_tb_clock (
    output logic cpu_clock,
    output logic rst_n
);

    // Period of 8
    initial begin
        cpu_clock = 1'b0;
        forever #4 cpu_clock = ~cpu_clock;
    end

    // Reset low for 8 cycles, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge cpu_clock);
        @(negedge cpu_clock);
        rst_n = 1'b1;
    end

endmodule

/* testbench/cpu_sva.sv */
module cpu_sva (
    input logic              cpu_clock,
    input logic              rst_n,
    input cpu_pkg::bus_req_t bus,
    input logic              halt
);

    // Halt is sticky until reset
    halt_sticky: assert property (
        @(posedge cpu_clock) disable iff (!rst_n)
        $past(halt) |-> halt
    ) else $error("halt dropped without a reset");

    // A halted core does not touch memory
    no_write_halted: assert property (
        @(posedge cpu_clock) disable iff (!rst_n)
        halt |-> !bus.wreq
    ) else $error("write request seen while halted");

    // No writes once reset has been seen for a cycle
    no_write_reset: assert property (
        @(posedge cpu_clock)
        (!rst_n && $past(!rst_n)) |-> !bus.wreq
    ) else $error("write request seen during reset");

endmodule

/* testbench/cpu_tb.sv */
`include "cpu_macros.svh"

module cpu_tb;

    logic              cpu_clock;
    logic              rst_n;
    logic [7:0]        i_data;
    cpu_pkg::bus_req_t bus;
    logic              halt;

    logic [7:0]        mem [0:65535];
    logic [7:0]        model_mem [0:65535];
    logic [31:0]       rng_state = 32'd84;
    logic [15:0]       gen_pc;
    int                prog_len;
    bit                gen_done = 1'b0;
    cpu_pkg::bus_req_t exp_writes [$];
    cpu_pkg::flags_t   model_flags;
    int                wr_idx = 0;
    int                write_errors = 0;
    int                flag_errors = 0;
    int                other_errors = 0;

    cpu_tb_clock clock_i (
        .cpu_clock (cpu_clock),
        .rst_n     (rst_n)
    );

    cpu dut_i (
        .cpu_clock (cpu_clock),
        .rst_n     (rst_n),
        .i_data    (i_data),
        .bus       (bus),
        .halt      (halt)
    );

    bind cpu cpu_sva sva_i (
        .cpu_clock (cpu_clock),
        .rst_n     (rst_n),
        .bus       (bus),
        .halt      (halt)
    );

    // Memory reads in the same cycle
    assign i_data = mem[bus.address];

    // Random source
    // --------------------
    function automatic logic [7:0] rand_byte();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[23:16];
    endfunction

    task automatic emit(input logic [7:0] b);
        mem[gen_pc] = b;
        gen_pc      = gen_pc + 16'd1;
    endtask

    // mode_sel: 0 IMM, 1 ZP, 2 ZPX, 3 ABS, 4 ABX, 5 ABY
    task automatic emit_group_one(input logic [2:0] aaa, input int mode_sel);
        logic [2:0] bbb;
        logic [7:0] hi;
        int         sel;
        sel = mode_sel;
        if (aaa == 3'd4 && sel == 0) begin
            sel = 1;
        end
        case (sel)
            0:       bbb = 3'b010;
            1:       bbb = 3'b001;
            2:       bbb = 3'b101;
            3:       bbb = 3'b011;
            4:       bbb = 3'b111;
            default: bbb = 3'b110;
        endcase
        emit({aaa, bbb, 2'b01});
        emit(rand_byte());
        if (sel >= 3) begin
            hi = rand_byte();
            emit(8'h30 + {7'd0, hi[0]});
        end
    endtask

    task automatic fill_memory();
        logic [15:0] ad;
        for (int i = 0; i < 65536; i++) begin
            ad     = i[15:0];
            mem[i] = ad[7:0] ^ ad[15:8] ^ 8'h5A;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = rand_byte();
        end
        // Data window for absolute modes
        for (int i = 16'h3000; i < 16'h3400; i++) begin
            mem[i] = rand_byte();
        end
    endtask

    task automatic gen_program(input int count);
        logic [7:0] r;
        logic [7:0] sel;
        gen_pc = `CPU_RESET_PC;
        emit(8'hA2);
        emit(rand_byte());
        emit(8'hA0);
        emit(rand_byte());
        for (int n = 0; n < count; n++) begin
            r = rand_byte();
            case (r[3:0])
                4'd0: begin
                    emit(8'hA2);
                    emit(rand_byte());
                end
                4'd1: begin
                    emit(8'hA0);
                    emit(rand_byte());
                end
                4'd2: emit(8'h18);
                4'd3: emit(8'h38);
                default: begin
                    sel = rand_byte();
                    emit_group_one(sel[2:0], rand_byte() % 6);
                    // Store right after CMP shows A survived
                    if (sel[2:0] == 3'd6) begin
                        emit_group_one(3'd4, 1 + rand_byte() % 5);
                    end
                end
            endcase
        end
        // Final A lands at 3400
        emit(8'h8D);
        emit(8'h00);
        emit(8'h34);
        emit(`CPU_OP_BRK);
        prog_len = int'(gen_pc - `CPU_RESET_PC);
    endtask

    // Reference model
    // --------------------
    task automatic run_model();
        logic [15:0]       pc;
        logic [15:0]       ad;
        logic [7:0]        op;
        logic [7:0]        ra;
        logic [7:0]        rx;
        logic [7:0]        ry;
        logic [7:0]        val;
        int                us;
        int                ss;
        cpu_pkg::flags_t   f;
        cpu_pkg::bus_req_t w;
        bit                valid;
        for (int i = 0; i < 65536; i++) begin
            model_mem[i] = mem[i];
        end
        pc = `CPU_RESET_PC;
        ra = 8'h00;
        rx = 8'h00;
        ry = 8'h00;
        f  = '0;
        for (int step = 0; step < 10000; step++) begin
            op = model_mem[pc];
            pc = pc + 16'd1;
            if (op == `CPU_OP_BRK) begin
                break;
            end
            if (op == 8'hA2 || op == 8'hA0) begin
                val = model_mem[pc];
                pc  = pc + 16'd1;
                if (op == 8'hA2) rx = val;
                else ry = val;
                f.n = val[7];
                f.z = (val == 8'h00);
            end else if (op == 8'h18) begin
                f.c = 1'b0;
            end else if (op == 8'h38) begin
                f.c = 1'b1;
            end else if (op[1:0] == 2'b01) begin
                valid = 1'b1;
                ad    = 16'h0000;
                val   = 8'h00;
                case (op[4:2])
                    3'b010: begin
                        // STA immediate runs as a one-byte no-operation
                        valid = (op[7:5] != 3'd4);
                        if (valid) begin
                            val = model_mem[pc];
                            pc  = pc + 16'd1;
                        end
                    end
                    3'b001, 3'b101: begin
                        ad = {8'h00, model_mem[pc]};
                        if (op[4]) ad[7:0] = ad[7:0] + rx;
                        pc = pc + 16'd1;
                    end
                    3'b011, 3'b111, 3'b110: begin
                        ad = {model_mem[pc + 16'd1], model_mem[pc]};
                        if (op[4:2] == 3'b111) ad = ad + {8'h00, rx};
                        if (op[4:2] == 3'b110) ad = ad + {8'h00, ry};
                        pc = pc + 16'd2;
                    end
                    default: valid = 1'b0;
                endcase
                if (valid && op[4:2] != 3'b010) begin
                    val = model_mem[ad];
                end
                if (valid) begin
                    case (op[7:5])
                        3'd0: ra = ra | val;
                        3'd1: ra = ra & val;
                        3'd2: ra = ra ^ val;
                        3'd3: begin
                            // Unsigned sum gives carry, signed sum gives overflow
                            us  = int'(ra) + int'(val) + int'(f.c);
                            ss  = int'($signed(ra)) + int'($signed(val)) + int'(f.c);
                            f.c = (us > 255);
                            f.v = (ss > 127) || (ss < -128);
                            ra  = us[7:0];
                        end
                        3'd4: begin
                            model_mem[ad] = ra;
                            w.address = ad;
                            w.wdata   = ra;
                            w.wreq    = 1'b1;
                            exp_writes.push_back(w);
                        end
                        3'd5: ra = val;
                        3'd6: begin
                            us  = int'(ra) - int'(val);
                            f.c = (ra >= val);
                            f.z = (ra == val);
                            f.n = us[7];
                        end
                        default: begin
                            // Carry set means no borrow
                            us  = int'(ra) - int'(val) - (1 - int'(f.c));
                            ss  = int'($signed(ra)) - int'($signed(val)) - (1 - int'(f.c));
                            f.c = (us >= 0);
                            f.v = (ss > 127) || (ss < -128);
                            ra  = us[7:0];
                        end
                    endcase
                    if (op[7:5] != 3'd4 && op[7:5] != 3'd6) begin
                        f.n = ra[7];
                        f.z = (ra == 8'h00);
                    end
                end
            end
        end
        model_flags = f;
    endtask

    // Compare tasks
    // --------------------
    task automatic check_write(input string name, input cpu_pkg::bus_req_t exp,
                               input cpu_pkg::bus_req_t act);
        string exp_s;
        string act_s;
        exp_s = $sformatf("addr=%h data=%h wreq=%b", exp.address, exp.wdata, exp.wreq);
        act_s = $sformatf("addr=%h data=%h wreq=%b", act.address, act.wdata, act.wreq);
        if (exp !== act) begin
            write_errors++;
            $display("** Error %s: expected %s, actual %s", name, exp_s, act_s);
        end
    endtask

    task automatic check_flags(input string name, input cpu_pkg::flags_t exp,
                               input cpu_pkg::flags_t act);
        if (exp !== act) begin
            flag_errors++;
            $display("** Error %s: expected nvzc=%b, actual nvzc=%b", name, exp, act);
        end
    endtask

    // Write capture, in bus order
    always @(posedge cpu_clock) begin
        if (rst_n && bus.wreq) begin
            mem[bus.address] <= bus.wdata;
            if (halt) begin
                other_errors++;
                $display("Write to %h happened after the core halted", bus.address);
            end
            if (wr_idx < exp_writes.size()) begin
                check_write($sformatf("store_%0d", wr_idx), exp_writes[wr_idx], bus);
            end else begin
                other_errors++;
                $display("Unexpected extra write to %h", bus.address);
            end
            wr_idx++;
        end
    end

    // Watchdog
    initial begin
        int limit;
        wait (gen_done);
        limit = prog_len * 4 + 8 + 64;
        #(limit * 8);
        $display("Timeout: core did not halt within %0d cycles", limit);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        cpu_pkg::bus_req_t first;
        fill_memory();
        gen_program(120);
        run_model();
        gen_done = 1'b1;

        // First cycle after reset is a fetch at the reset PC
        wait (rst_n === 1'b1);
        #2;
        first.address = `CPU_RESET_PC;
        first.wdata   = 8'h00;
        first.wreq    = 1'b0;
        check_write("reset_fetch", first, bus);
        if (halt !== 1'b0) begin
            other_errors++;
            $display("** Error reset_halt: expected %b, actual %b", 1'b0, halt);
        end

        wait (halt === 1'b1);
        repeat (4) @(negedge cpu_clock);

        if (wr_idx != exp_writes.size()) begin
            other_errors++;
            $display("** Error write_count: expected %0d, actual %0d",
                     exp_writes.size(), wr_idx);
        end
        check_flags("final_flags", model_flags, dut_i.flags);

        $display("Errors: writes=%0d flags=%0d other=%0d",
                 write_errors, flag_errors, other_errors);
        if (write_errors == 0 && flag_errors == 0 && other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+verilog
verilog/cpu_pkg.sv
verilog/cpu_decoder.sv
verilog/cpu_sequencer.sv
verilog/cpu_addr_gen.sv
verilog/cpu_alu.sv
verilog/cpu_regfile.sv
verilog/cpu.sv
testbench/cpu_tb_clock.sv
testbench/cpu_sva.sv
testbench/cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
